//--- common/armCtrl_config.svh
`ifndef ARMCTRL_CONFIG_SVH
`define ARMCTRL_CONFIG_SVH

// Fetched instruction word
`define INSTR_WIDTH 32

// Stored condition flags, NZCV order
`define FLAG_WIDTH 4

// Register number of the program counter
`define PC_REG 15

`endif

//--- common/armCtrlPkg.sv
`default_nettype none

package armCtrlPkg;

  // Data-processing command field, bits 24:21
  typedef enum logic [3:0] {
    CMD_AND = 4'h0, CMD_EOR = 4'h1, CMD_SUB = 4'h2, CMD_RSB = 4'h3,
    CMD_ADD = 4'h4, CMD_ADC = 4'h5, CMD_SBC = 4'h6, CMD_RSC = 4'h7,
    CMD_TST = 4'h8, CMD_TEQ = 4'h9, CMD_CMP = 4'hA, CMD_CMN = 4'hB,
    CMD_ORR = 4'hC, CMD_MOV = 4'hD, CMD_BIC = 4'hE, CMD_MVN = 4'hF
  } aluCmd_e;

  // Condition field, bits 31:28; 4'hF is left unnamed and never executes
  typedef enum logic [3:0] {
    COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3,
    COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7,
    COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'hA, COND_LT = 4'hB,
    COND_GT = 4'hC, COND_LE = 4'hD, COND_AL = 4'hE
  } cond_e;

  // Operation performed by the ALU core
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_AND   = 3'd1,
    ALU_EOR   = 3'd2,
    ALU_ORR   = 3'd3,
    ALU_PASSB = 3'd4  // MOV and MVN
  } aluOperation_e;

  typedef struct packed {
    cond_e       cond;
    logic [1:0]  op;
    logic        immFlag;
    aluCmd_e     cmd;
    logic        sBit;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpView_t;

  typedef struct packed {
    cond_e       cond;
    logic [1:0]  op;
    logic        immFlag;    // Set means register offset
    logic        preIndex;
    logic        upBit;
    logic        byteBit;
    logic        writeBack;
    logic        loadBit;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memView_t;

  // One word, decoded as data processing or as load/store
  typedef union packed {
    dpView_t  dp;
    memView_t mem;
  } instrWord_u;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       aluOp;
    logic       multSelect;
    logic [1:0] flagWrite;   // {NZ, CV}
    logic       pcSrc;
    aluCmd_e    aluControl;
    logic [2:0] multControl;
  } decodeCtrl_t;

  typedef struct packed {
    aluOperation_e aluOperation;
    logic [2:0]    cvUpdate;  // [0] V, [1] C from adder, [2] C from shifter
    logic          invertB;
    logic          reverseInputs;
    logic          aluCarry;
  } aluCtrl_t;

  // Bundle carried E to M and M to W
  typedef struct packed {
    logic memWrite;
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } memCtrl_t;

endpackage

`default_nettype wire

//--- design/mainDecoder.sv
`default_nettype none

`include "armCtrl_config.svh"

module mainDecoder (
  input  armCtrlPkg::instrWord_u  instrD,
  input  logic [3:0]              rfRzD,
  output armCtrlPkg::decodeCtrl_t decodeD
);

  logic isMemory;   // LDR or STR
  logic pcWrite;

  assign isMemory = (instrD.mem.op == 2'b01);

  always_comb begin
    decodeD = '0;  // Opcode 11 stays all zero

    case (instrD.dp.op)
      2'b00: begin
        decodeD.regWrite = 1'b1;
        decodeD.aluOp    = 1'b1;
        if (instrD.dp.immFlag) begin
          decodeD.aluSrc = 1'b1;  // Rotated immediate
        end else if (instrD.dp.operand2[7:4] == 4'b1001) begin
          decodeD.multSelect = 1'b1;
        end
      end

      2'b01: begin
        decodeD.immSrc = 2'b01;
        decodeD.memtoReg = 1'b1;
        if (instrD.mem.loadBit) begin
          decodeD.regWrite = 1'b1;
          decodeD.aluSrc   = ~instrD.mem.immFlag;  // Immediate offset when I is clear
        end else begin
          // Store reads Rd as the data register
          decodeD.regSrc   = 2'b10;
          decodeD.aluSrc   = ~instrD.mem.immFlag;
          decodeD.memWrite = 1'b1;
        end
      end

      2'b10: begin
        decodeD.regSrc = 2'b01;  // Base is the PC
        decodeD.immSrc = 2'b10;
        decodeD.aluSrc = 1'b1;
        decodeD.branch = 1'b1;
      end

      default: ;
    endcase

    if (instrD.dp.op != 2'b11) begin
      decodeD.multControl = instrD.dp.cmd[2:0];
      if (decodeD.aluOp) begin
        decodeD.aluControl = instrD.dp.cmd;
        decodeD.flagWrite  = {2{instrD.dp.sBit}};  // S updates both flag halves
      end else if (isMemory && !instrD.mem.upBit) begin
        decodeD.aluControl = armCtrlPkg::CMD_SUB;  // Negative offset
      end else begin
        decodeD.aluControl = armCtrlPkg::CMD_ADD;
      end
    end

    decodeD.pcSrc = pcWrite;
  end

  // Writes to R15 redirect fetch unless the register file claims the port
  assign pcWrite = (instrD.dp.op == 2'b10)
                 | ((instrD.dp.rd == 4'(`PC_REG)) && (instrD.dp.op != 2'b11)
                    && (instrD.dp.op != 2'b10) && !(isMemory && !instrD.mem.loadBit)
                    && !rfRzD[2]);

endmodule

`default_nettype wire

//--- design/aluDecoder.sv
`default_nettype none

module aluDecoder (
  input  logic                aluOpE,
  input  armCtrlPkg::aluCmd_e cmdE,
  input  logic                carryIn,
  output armCtrlPkg::aluCtrl_t aluCtrlE,
  output logic                doNotWriteReg
);

  localparam logic [2:0] CV_LOGIC = 3'b100;  // Carry out of the shifter
  localparam logic [2:0] CV_ARITH = 3'b011;  // Carry and overflow from adder

  always_comb begin
    aluCtrlE      = '0;
    doNotWriteReg = 1'b0;
    aluCtrlE.aluOperation = armCtrlPkg::ALU_ADD;  // Address add when not data processing

    if (aluOpE) begin
      case (cmdE)
        armCtrlPkg::CMD_AND,
        armCtrlPkg::CMD_TST: aluCtrlE.aluOperation = armCtrlPkg::ALU_AND;
        armCtrlPkg::CMD_EOR,
        armCtrlPkg::CMD_TEQ: aluCtrlE.aluOperation = armCtrlPkg::ALU_EOR;
        armCtrlPkg::CMD_ORR: aluCtrlE.aluOperation = armCtrlPkg::ALU_ORR;
        armCtrlPkg::CMD_MOV: aluCtrlE.aluOperation = armCtrlPkg::ALU_PASSB;
        armCtrlPkg::CMD_BIC: begin
          aluCtrlE.aluOperation = armCtrlPkg::ALU_AND;
          aluCtrlE.invertB      = 1'b1;
        end
        armCtrlPkg::CMD_MVN: begin
          aluCtrlE.aluOperation = armCtrlPkg::ALU_PASSB;
          aluCtrlE.invertB      = 1'b1;
        end
        // A - B is A + ~B + 1
        armCtrlPkg::CMD_SUB,
        armCtrlPkg::CMD_CMP: begin
          aluCtrlE.invertB  = 1'b1;
          aluCtrlE.aluCarry = 1'b1;
        end
        armCtrlPkg::CMD_RSB: begin
          aluCtrlE.invertB       = 1'b1;
          aluCtrlE.reverseInputs = 1'b1;
          aluCtrlE.aluCarry      = 1'b1;
        end
        armCtrlPkg::CMD_ADC: aluCtrlE.aluCarry = carryIn;
        armCtrlPkg::CMD_SBC: begin
          aluCtrlE.invertB  = 1'b1;
          aluCtrlE.aluCarry = carryIn;  // Borrow is ~C
        end
        armCtrlPkg::CMD_RSC: begin
          aluCtrlE.invertB       = 1'b1;
          aluCtrlE.reverseInputs = 1'b1;
          aluCtrlE.aluCarry      = carryIn;
        end
        default: ;  // ADD and CMN, plain add with carry 0
      endcase

      // Logic and move commands leave V alone
      if (aluCtrlE.aluOperation == armCtrlPkg::ALU_ADD) begin
        aluCtrlE.cvUpdate = CV_ARITH;
      end else begin
        aluCtrlE.cvUpdate = CV_LOGIC;
      end

      // Compare group only sets flags
      doNotWriteReg = (cmdE[3:2] == 2'b10);
    end
  end

endmodule

`default_nettype wire

//--- condUnit/condUnit.sv
`default_nettype none

`include "armCtrl_config.svh"

module condUnit (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    stallE,
  input  armCtrlPkg::cond_e       condE,
  input  logic [`FLAG_WIDTH-1:0]  flagsE,
  input  logic [1:0]              flagWriteE,
  input  armCtrlPkg::memCtrl_t    ctrlE,
  input  logic                    branchE,
  input  logic                    doNotWriteReg,
  output logic [`FLAG_WIDTH-1:0]  previousFlagsE,
  output logic                    branchTakenE,
  output armCtrlPkg::memCtrl_t    ctrlGatedE
);

  logic flagN;
  logic flagZ;
  logic flagC;
  logic flagV;
  logic condEx;

  assign {flagN, flagZ, flagC, flagV} = previousFlagsE;

  always_comb begin
    case (condE)
      armCtrlPkg::COND_EQ: condEx = flagZ;
      armCtrlPkg::COND_NE: condEx = ~flagZ;
      armCtrlPkg::COND_CS: condEx = flagC;
      armCtrlPkg::COND_CC: condEx = ~flagC;
      armCtrlPkg::COND_MI: condEx = flagN;
      armCtrlPkg::COND_PL: condEx = ~flagN;
      armCtrlPkg::COND_VS: condEx = flagV;
      armCtrlPkg::COND_VC: condEx = ~flagV;
      armCtrlPkg::COND_HI: condEx = flagC & ~flagZ;
      armCtrlPkg::COND_LS: condEx = ~flagC | flagZ;
      armCtrlPkg::COND_GE: condEx = ~(flagN ^ flagV);
      armCtrlPkg::COND_LT: condEx = flagN ^ flagV;
      armCtrlPkg::COND_GT: condEx = ~flagZ & ~(flagN ^ flagV);
      armCtrlPkg::COND_LE: condEx = flagZ | (flagN ^ flagV);
      armCtrlPkg::COND_AL: condEx = 1'b1;
      default:             condEx = 1'b0;  // 4'hF never executes
    endcase
  end

  // NZCV register, split into NZ and CV write halves
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      previousFlagsE <= '0;
    end else if (!stallE) begin
      if (condEx && flagWriteE[1]) begin
        previousFlagsE[3:2] <= flagsE[3:2];
      end
      if (condEx && flagWriteE[0]) begin
        previousFlagsE[1:0] <= flagsE[1:0];
      end
    end
  end

  assign branchTakenE = branchE & condEx;

  always_comb begin
    ctrlGatedE          = ctrlE;
    ctrlGatedE.memWrite = ctrlE.memWrite & condEx;
    ctrlGatedE.regWrite = ctrlE.regWrite & condEx & ~doNotWriteReg;  // Compares never write
    ctrlGatedE.pcSrc    = ctrlE.pcSrc & condEx;
  end

endmodule

`default_nettype wire

//--- design/controller.sv
`default_nettype none

`include "armCtrl_config.svh"

module controller (
  input  logic                    clk,
  input  logic                    arstN,
  input  armCtrlPkg::instrWord_u  instrD,
  input  logic [`FLAG_WIDTH-1:0]  flagsE,
  input  logic [3:0]              rfRzD,
  input  logic                    stallE,
  input  logic                    flushE,
  input  logic                    stallM,
  input  logic                    stallW,
  input  logic                    flushW,
  output logic [1:0]              regSrcD,
  output logic [1:0]              immSrcD,
  output logic                    aluSrcE,
  output armCtrlPkg::aluCmd_e     aluControlE,
  output logic [2:0]              multControlE,
  output logic                    multEnableE,
  output armCtrlPkg::aluCtrl_t    aluCtrlE,
  output logic                    branchTakenE,
  output logic                    memtoRegE,
  output logic [`FLAG_WIDTH-1:0]  previousFlagsE,
  output armCtrlPkg::memCtrl_t    memCtrlM,
  output armCtrlPkg::memCtrl_t    memCtrlW,
  output logic                    pcWrPendingF
);

  armCtrlPkg::decodeCtrl_t decodeD;
  armCtrlPkg::decodeCtrl_t decodeE;
  armCtrlPkg::instrWord_u  instrE;
  armCtrlPkg::memCtrl_t    ctrlE;
  armCtrlPkg::memCtrl_t    ctrlGatedE;
  logic                    doNotWriteReg;

  mainDecoder i_mainDecoder (
    .instrD  (instrD),
    .rfRzD   (rfRzD),
    .decodeD (decodeD)
  );

  assign regSrcD = decodeD.regSrc;
  assign immSrcD = decodeD.immSrc;

  // E registers, cleared by a flush only when the stage advances
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decodeE <= '0;
      instrE  <= '0;
    end else if (!stallE) begin
      if (flushE) begin
        decodeE <= '0;
        instrE  <= '0;
      end else begin
        decodeE <= decodeD;
        instrE  <= instrD;  // Carries the condition field too
      end
    end
  end

  assign aluSrcE      = decodeE.aluSrc;
  assign aluControlE  = decodeE.aluControl;
  assign multControlE = decodeE.multControl;
  assign memtoRegE    = decodeE.memtoReg;
  assign multEnableE  = decodeE.multSelect;  // Register form with bits 7:4 = 1001

  aluDecoder i_aluDecoder (
    .aluOpE        (decodeE.aluOp),
    .cmdE          (instrE.dp.cmd),
    .carryIn       (previousFlagsE[1]),  // Stored C
    .aluCtrlE      (aluCtrlE),
    .doNotWriteReg (doNotWriteReg)
  );

  assign ctrlE.memWrite = decodeE.memWrite;
  assign ctrlE.memtoReg = decodeE.memtoReg;
  assign ctrlE.regWrite = decodeE.regWrite;
  assign ctrlE.pcSrc    = decodeE.pcSrc;

  condUnit i_condUnit (
    .clk            (clk),
    .arstN          (arstN),
    .stallE         (stallE),
    .condE          (instrE.dp.cond),
    .flagsE         (flagsE),
    .flagWriteE     (decodeE.flagWrite),
    .ctrlE          (ctrlE),
    .branchE        (decodeE.branch),
    .doNotWriteReg  (doNotWriteReg),
    .previousFlagsE (previousFlagsE),
    .branchTakenE   (branchTakenE),
    .ctrlGatedE     (ctrlGatedE)
  );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrlM <= '0;
    end else if (!stallM) begin
      memCtrlM <= ctrlGatedE;  // No flush in M
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrlW <= '0;
    end else if (!stallW) begin
      if (flushW) begin
        memCtrlW <= '0;
      end else begin
        memCtrlW <= memCtrlM;
      end
    end
  end

  // Any PC write still in flight holds off fetch
  assign pcWrPendingF = decodeD.pcSrc | decodeE.pcSrc | memCtrlM.pcSrc;

endmodule

`default_nettype wire

//--- tests/controller_props.sv
`default_nettype none

`include "armCtrl_config.svh"

module controllerProps (
  input logic                    clk,
  input logic                    arstN,
  input armCtrlPkg::instrWord_u  instrD,
  input logic [`FLAG_WIDTH-1:0]  flagsE,
  input logic [3:0]              rfRzD,
  input logic                    stallE,
  input logic                    flushE,
  input logic                    stallM,
  input logic                    stallW,
  input logic                    flushW,
  input logic [1:0]              regSrcD,
  input logic [1:0]              immSrcD,
  input logic                    aluSrcE,
  input armCtrlPkg::aluCmd_e     aluControlE,
  input logic [2:0]              multControlE,
  input logic                    multEnableE,
  input armCtrlPkg::aluCtrl_t    aluCtrlE,
  input logic                    branchTakenE,
  input logic                    memtoRegE,
  input logic [`FLAG_WIDTH-1:0]  previousFlagsE,
  input armCtrlPkg::memCtrl_t    memCtrlM,
  input armCtrlPkg::memCtrl_t    memCtrlW,
  input logic                    pcWrPendingF
);
  timeunit 1ns;
  timeprecision 100ps;

  int errorCount = 0;

  armCtrlPkg::instrWord_u instE;  // Instruction now in Execute
  logic                   validE;
  logic                   pcSrcE;
  logic                   condE;
  logic [1:0]             flagWriteE;
  logic                   regWriteE;
  logic                   memWriteE;
  logic [3:0]             nextFlags;
  logic [3:0]             flagsModel;  // Stored NZCV built from the rules
  logic                   aluSrcExp;
  logic                   memtoRegExp;
  logic                   multExp;
  armCtrlPkg::memCtrl_t   ctrlExpE;
  armCtrlPkg::memCtrl_t   ctrlExpM;
  armCtrlPkg::memCtrl_t   ctrlExpW;

  task automatic reportFail(input string what);
    $error("FAIL %s", what);
    errorCount++;
  endtask

  // Data processing or LDR
  function automatic logic writesReg(armCtrlPkg::instrWord_u w);
    return (w.dp.op == 2'b00) || (w.mem.op == 2'b01 && w.mem.loadBit);
  endfunction

  function automatic logic pcRule(armCtrlPkg::instrWord_u w, logic [3:0] rz);
    return (w.dp.op == 2'b10) || (writesReg(w) && w.dp.rd == 4'(`PC_REG) && !rz[2]);
  endfunction

  // Returns {regSrc, immSrc}
  function automatic logic [3:0] srcRule(armCtrlPkg::instrWord_u w);
    case (w.dp.op)
      2'b01:   return {(w.mem.loadBit ? 2'b00 : 2'b10), 2'b01};
      2'b10:   return 4'b0110;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic armCtrlPkg::aluCmd_e cmdRule(armCtrlPkg::instrWord_u w);
    if (w.dp.op == 2'b00) return w.dp.cmd;
    if (w.dp.op == 2'b01 && !w.mem.upBit) return armCtrlPkg::CMD_SUB;
    return armCtrlPkg::CMD_ADD;
  endfunction

  function automatic armCtrlPkg::aluCtrl_t aluRule(armCtrlPkg::instrWord_u w, logic c);
    armCtrlPkg::aluCtrl_t r;
    armCtrlPkg::aluCmd_e  cmd;
    r = '0;
    cmd = w.dp.cmd;
    if (w.dp.op != 2'b00) return r;  // Plain address add
    case (cmd)
      armCtrlPkg::CMD_AND, armCtrlPkg::CMD_TST,
      armCtrlPkg::CMD_BIC: r.aluOperation = armCtrlPkg::ALU_AND;
      armCtrlPkg::CMD_EOR, armCtrlPkg::CMD_TEQ: r.aluOperation = armCtrlPkg::ALU_EOR;
      armCtrlPkg::CMD_ORR: r.aluOperation = armCtrlPkg::ALU_ORR;
      armCtrlPkg::CMD_MOV, armCtrlPkg::CMD_MVN: r.aluOperation = armCtrlPkg::ALU_PASSB;
      default: r.aluOperation = armCtrlPkg::ALU_ADD;
    endcase
    r.invertB = cmd inside {armCtrlPkg::CMD_SUB, armCtrlPkg::CMD_RSB, armCtrlPkg::CMD_SBC,
                            armCtrlPkg::CMD_RSC, armCtrlPkg::CMD_CMP, armCtrlPkg::CMD_BIC,
                            armCtrlPkg::CMD_MVN};
    r.reverseInputs = cmd inside {armCtrlPkg::CMD_RSB, armCtrlPkg::CMD_RSC};
    if (cmd inside {armCtrlPkg::CMD_SUB, armCtrlPkg::CMD_RSB, armCtrlPkg::CMD_CMP}) begin
      r.aluCarry = 1'b1;
    end else if (cmd inside {armCtrlPkg::CMD_ADC, armCtrlPkg::CMD_SBC, armCtrlPkg::CMD_RSC}) begin
      r.aluCarry = c;
    end
    r.cvUpdate = (r.aluOperation == armCtrlPkg::ALU_ADD) ? 3'b011 : 3'b100;
    return r;
  endfunction

  // Even codes test a flag term, odd codes its inverse
  function automatic logic condOk(logic [3:0] cond, logic [3:0] nzcv);
    logic base;
    case (cond[3:1])
      3'd0:    base = nzcv[2];
      3'd1:    base = nzcv[1];
      3'd2:    base = nzcv[3];
      3'd3:    base = nzcv[0];
      3'd4:    base = nzcv[1] & ~nzcv[2];
      3'd5:    base = (nzcv[3] == nzcv[0]);
      3'd6:    base = ~nzcv[2] & (nzcv[3] == nzcv[0]);
      default: base = 1'b1;
    endcase
    return (cond != 4'hF) && (base ^ cond[0]);
  endfunction

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instE      <= '0;
      validE     <= 1'b0;
      pcSrcE     <= 1'b0;
      flagsModel <= '0;
    end else if (!stallE) begin
      instE      <= instrD;
      validE     <= !flushE;
      pcSrcE     <= !flushE && pcRule(instrD, rfRzD);
      flagsModel <= nextFlags;
    end
  end

  // Expected M and W bundles
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlExpM <= '0;
      ctrlExpW <= '0;
    end else begin
      if (!stallM) begin
        ctrlExpM <= ctrlExpE;
      end
      if (!stallW) begin
        ctrlExpW <= flushW ? '0 : ctrlExpM;
      end
    end
  end

  assign condE      = condOk(instE.dp.cond, flagsModel);
  assign flagWriteE = (validE && instE.dp.op == 2'b00) ? {2{instE.dp.sBit}} : 2'b00;
  assign regWriteE  = validE && condE && writesReg(instE)
                    && !(instE.dp.op == 2'b00 && instE.dp.cmd inside {armCtrlPkg::CMD_TST,
                         armCtrlPkg::CMD_TEQ, armCtrlPkg::CMD_CMP, armCtrlPkg::CMD_CMN});
  assign memWriteE  = validE && condE && instE.mem.op == 2'b01 && !instE.mem.loadBit;
  assign nextFlags[3:2] = (condE && flagWriteE[1]) ? flagsE[3:2] : flagsModel[3:2];
  assign nextFlags[1:0] = (condE && flagWriteE[0]) ? flagsE[1:0] : flagsModel[1:0];

  // Immediate operand for DP immediate, memory with I clear, and branch
  assign aluSrcExp   = validE && ((instE.dp.op == 2'b00 && instE.dp.immFlag)
                     || (instE.mem.op == 2'b01 && !instE.mem.immFlag) || instE.dp.op == 2'b10);
  assign memtoRegExp = validE && instE.mem.op == 2'b01;
  assign multExp     = validE && instE.dp.op == 2'b00 && !instE.dp.immFlag
                     && instE.dp.operand2[7:4] == 4'b1001;

  assign ctrlExpE.memWrite = memWriteE;
  assign ctrlExpE.memtoReg = memtoRegExp;
  assign ctrlExpE.regWrite = regWriteE;
  assign ctrlExpE.pcSrc    = pcSrcE && condE;

  assert property (@(posedge clk) disable iff (!arstN) {regSrcD, immSrcD} == srcRule(instrD))
    else reportFail($sformatf("regSrcD/immSrcD got %h expected %h",
                              {regSrcD, immSrcD}, srcRule(instrD)));

  assert property (@(posedge clk) disable iff (!arstN)
    pcWrPendingF == (pcRule(instrD, rfRzD) || pcSrcE || ctrlExpM.pcSrc))
    else reportFail($sformatf("pcWrPendingF got %h expected %h", pcWrPendingF,
                              pcRule(instrD, rfRzD) || pcSrcE || ctrlExpM.pcSrc));

  assert property (@(posedge clk) disable iff (!arstN) (!stallE && !flushE) |=>
    (aluControlE == cmdRule($past(instrD))
     && aluCtrlE == aluRule($past(instrD), flagsModel[1])))
    else reportFail($sformatf("aluControlE/aluCtrlE got %h/%h", aluControlE, aluCtrlE));

  // Multiply opcode sits in bits 23:21
  assert property (@(posedge clk) disable iff (!arstN)
    ({aluSrcE, memtoRegE, multEnableE} == {aluSrcExp, memtoRegExp, multExp}
     && ((validE && !multExp) || multControlE == (validE ? instE.dp.cmd[2:0] : 3'b000))))
    else reportFail($sformatf("aluSrcE/memtoRegE/multEnableE/multControlE got %h/%h/%h/%h expected %h/%h/%h",
                              aluSrcE, memtoRegE, multEnableE, multControlE,
                              aluSrcExp, memtoRegExp, multExp));

  assert property (@(posedge clk) disable iff (!arstN)
    branchTakenE == (validE && condE && instE.dp.op == 2'b10))
    else reportFail($sformatf("branchTakenE got %h", branchTakenE));

  assert property (@(posedge clk) disable iff (!arstN) memCtrlM == ctrlExpM)
    else reportFail($sformatf("memCtrlM got %h expected %h", memCtrlM, ctrlExpM));

  assert property (@(posedge clk) disable iff (!arstN) previousFlagsE == flagsModel)
    else reportFail($sformatf("previousFlagsE got %h expected %h", previousFlagsE, flagsModel));

  assert property (@(posedge clk) disable iff (!arstN) (flushE && !stallE) |=>
    (aluControlE == armCtrlPkg::CMD_AND && aluCtrlE == '0 && !branchTakenE))
    else reportFail($sformatf("flushed E controls got %h/%h", aluControlE, aluCtrlE));

  // All three stages stall together
  assert property (@(posedge clk) disable iff (!arstN) (stallE && stallM && stallW) |=>
    ($stable(aluControlE) && $stable(previousFlagsE) && $stable(memCtrlM)
     && $stable(memCtrlW)))
    else reportFail($sformatf("stalled memCtrlM/memCtrlW got %h/%h", memCtrlM, memCtrlW));

  assert property (@(posedge clk) disable iff (!arstN) memCtrlW == ctrlExpW)
    else reportFail($sformatf("memCtrlW got %h expected %h", memCtrlW, ctrlExpW));

  assert property (@(posedge clk) disable iff (!arstN)
    (!stallW && flushW) |=> memCtrlW == '0)
    else reportFail($sformatf("memCtrlW got %h expected 0", memCtrlW));

  assert property (@(posedge clk) !arstN |->
    (memCtrlM == '0 && memCtrlW == '0 && !branchTakenE && previousFlagsE == '0))
    else reportFail($sformatf("reset state M/W/flags got %h/%h/%h",
                              memCtrlM, memCtrlW, previousFlagsE));

endmodule

`default_nettype wire

//--- tests/controllerTb.sv
`default_nettype none

`include "armCtrl_config.svh"

module controllerTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int numInstr      = 3000;
  localparam int resetCycles   = 16;
  localparam int timeoutCycles = 3500;  // Reset, instructions and drain, with margin

  logic                   clk = 1'b0;
  logic                   arstN;
  armCtrlPkg::instrWord_u instrD;
  logic [3:0]             flagsE;
  logic [3:0]             rfRzD;
  logic                   stallE;
  logic                   flushE;
  logic                   stallM;
  logic                   stallW;
  logic                   flushW;
  logic [1:0]             regSrcD;
  logic [1:0]             immSrcD;
  logic                   aluSrcE;
  armCtrlPkg::aluCmd_e    aluControlE;
  logic [2:0]             multControlE;
  logic                   multEnableE;
  armCtrlPkg::aluCtrl_t   aluCtrlE;
  logic                   branchTakenE;
  logic                   memtoRegE;
  logic [3:0]             previousFlagsE;
  armCtrlPkg::memCtrl_t   memCtrlM;
  armCtrlPkg::memCtrl_t   memCtrlW;
  logic                   pcWrPendingF;
  int                     cycleCount = 0;

  controller i_controller (.*);

  bind controller controllerProps i_props (.*);

  always #5 clk = ~clk;

  // Random word forced into one of the supported classes
  function automatic logic [`INSTR_WIDTH-1:0] randomInstr();
    logic [`INSTR_WIDTH-1:0] w;
    w = $urandom();
    case ($urandom_range(5, 0))
      0: w[27:25] = 3'b001;  // DP immediate
      1: begin
        w[27:25] = 3'b000;
        w[7:4]   = 4'b1001;  // Multiply
      end
      2: w[27:25] = 3'b000;
      3: begin
        w[27:26] = 2'b01;
        w[20]    = 1'b1;  // LDR
      end
      4: begin
        w[27:26] = 2'b01;
        w[20]    = 1'b0;
      end
      default: w[27:25] = 3'b101;  // B
    endcase
    return w;
  endfunction

  task automatic driveRandomInputs();
    logic stall;
    stall  = ($urandom_range(9, 0) == 0);
    instrD = randomInstr();
    flagsE = 4'($urandom());
    rfRzD  = 4'($urandom());
    stallE = stall;
    stallM = stall;
    stallW = stall;
    flushE = ($urandom_range(11, 0) == 0);
    flushW = ($urandom_range(15, 0) == 0);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (i_controller.i_props.errorCount != 0) begin
      $display("Test FAILED");
      $fatal(1, "An assertion on the controller failed");
    end else if (cycleCount >= timeoutCycles) begin
      $display("Test FAILED");
      $fatal(1, "Run did not finish within %0d cycles", timeoutCycles);
    end
  end

  initial begin
    void'($urandom(53));
    arstN  = 1'b0;
    instrD = '0;
    flagsE = '0;
    rfRzD  = '0;
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    arstN = 1'b1;
    for (int n = 0; n < numInstr; n++) begin
      driveRandomInputs();
      @(posedge clk);
      #1;
    end
    {stallE, stallM, stallW, flushE, flushW} = '0;
    repeat (4) @(posedge clk);  // Drain W and let the last checks settle
    #1;
    if (i_controller.i_props.errorCount == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "Assertion failures were counted at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/armCtrlPkg.sv
design/mainDecoder.sv
design/aluDecoder.sv
condUnit/condUnit.sv
design/controller.sv
tests/controller_props.sv
tests/controllerTb.sv

//--- Makefile
VERILATOR    = verilator
TOP          = controllerTb
FILELIST     = sim.f
OBJDIR       = obj_dir
COMMON_FLAGS = --timing --assert --timescale 1ns/100ps -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS   = --lint-only
SIM_FLAGS    = --binary --Mdir $(OBJDIR)
PASS_MSG     = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

# Pass only if the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
